// File: vlog.f
common/CorePkg.sv
hw/decode/InstrDecoder.sv
hw/RegFile.sv
hw/IssueStage.sv
hw/ExecuteStage.sv
hw/IntCore.sv
test/IntCore_sva.sv
test/IntCoreTb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module IntCoreTb -f vlog.f -o simv
status=$?
if [ $status -ne 0 ]; then
    echo "build failed"
    exit $status
fi

./obj_dir/simv
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi
exit 0

// File: test/IntCoreTb.sv
`timescale 1ns/100ps

module IntCoreTb;
    import CorePkg::*;

    typedef struct {
        logic        res;
        logic [4:0]  rd;
        logic [31:0] val;
        logic        br;
        logic [31:0] tgt;
        logic        dsp;
        FuncUnit     fu;
        UopOpcode    uop;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [4:0]  drd;
        logic        ill;
        logic [31:0] ipc;
    } Expect;

    logic        clk = 1'b0;
    logic        rstN;
    logic        instrValid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        resultValid;
    logic [4:0]  resultRd;
    logic [31:0] result;
    logic        branchTaken;
    logic [31:0] branchTarget;
    logic        dispatchValid;
    FuncUnit     dispatchFu;
    UopOpcode    dispatchOpcode;
    logic [31:0] dispatchSrcA;
    logic [31:0] dispatchSrcB;
    logic [31:0] dispatchImm;
    logic [4:0]  dispatchRd;
    logic        illegalInstr;
    logic [31:0] illegalPc;

    integer      seed;
    logic [31:0] rf [32];
    Expect       pipe [$];

    IntCore IntCore_inst (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] rnd();
        rnd = $random(seed);
    endfunction

    task automatic failOn(input string what);
        $display("Run aborted: %s", what);
        $display("** FAIL **");
        $fatal(1, "stopping after an error");
    endtask

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic checkWord(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            $display("** FAIL **");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic checkReg(input string name, input logic [4:0] exp, input logic [4:0] act);
        if (exp !== act) begin
            $display("ERR %s: expected x%0d, actual x%0d", name, exp, act);
            $display("** FAIL **");
            $fatal(1, "register mismatch");
        end
    endtask

    task automatic checkFu(input string name, input FuncUnit exp, input FuncUnit act);
        if (exp !== act) begin
            $display("ERR %s: expected %s, actual %s", name, exp.name(), act.name());
            $display("** FAIL **");
            $fatal(1, "unit mismatch");
        end
    endtask

    task automatic checkUop(input string name, input UopOpcode exp, input UopOpcode act);
        if (exp !== act) begin
            $display("ERR %s: expected %s, actual %s", name, exp.name(), act.name());
            $display("** FAIL **");
            $fatal(1, "micro-op mismatch");
        end
    endtask

    function automatic Expect noneExp();
        noneExp.res = 1'b0;
        noneExp.br  = 1'b0;
        noneExp.dsp = 1'b0;
        noneExp.ill = 1'b0;
    endfunction

    // Integer ALU as defined by the RV32I spec.
    function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] x, input logic [31:0] y);
        case (f3)
            3'd0: aluModel = alt ? x - y : x + y;
            3'd1: aluModel = x << y[4:0];
            3'd2: aluModel = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'd3: aluModel = (x < y) ? 32'd1 : 32'd0;
            3'd4: aluModel = x ^ y;
            3'd5: begin
                if (alt) begin
                    aluModel = $signed(x) >>> y[4:0];
                end else begin
                    aluModel = x >> y[4:0];
                end
            end
            3'd6: aluModel = x | y;
            default: aluModel = x & y;
        endcase
    endfunction

    // ------------------------------
    // Generator and reference model
    // ------------------------------
    task automatic makeInstr(input logic [31:0] pcIn, output logic [31:0] ins, output Expect e);
        logic [31:0] fld;
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        alt;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        int          cls;
        fld = rnd();
        r   = rnd();
        cls = int'(fld[31:16] % 16'd11);
        rd  = {2'b0, fld[2:0]};
        rs1 = {2'b0, fld[5:3]};
        rs2 = {2'b0, fld[8:6]};
        f3  = fld[11:9];
        alt = fld[12] && (f3 == 3'd0 || f3 == 3'd5);
        a   = rf[rs1];
        b   = rf[rs2];
        e   = noneExp();
        imm = {{20{r[31]}}, r[31:20]};
        case (cls)
            0: begin
                ins   = {alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'b0110011};
                e.res = 1'b1;
                e.val = aluModel(f3, alt, a, b);
            end
            1: begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    f7  = fld[12] && f3 == 3'd5 ? 7'h20 : 7'h00;
                    ins = {f7, r[24:20], rs1, f3, rd, 7'b0010011};
                    imm = {{20{f7[6]}}, f7, r[24:20]};
                end else begin
                    ins = {r[31:20], rs1, f3, rd, 7'b0010011};
                end
                e.res = 1'b1;
                e.val = aluModel(f3, f3 == 3'd5 && ins[30], a, imm);
            end
            2, 3: begin
                ins   = {r[31:12], rd, cls == 2 ? 7'b0110111 : 7'b0010111};
                e.res = 1'b1;
                e.val = cls == 2 ? {r[31:12], 12'b0} : pcIn + {r[31:12], 12'b0};
            end
            4: begin
                ins   = {r[31], r[30:21], r[20], r[19:12], rd, 7'b1101111};
                imm   = {{11{r[31]}}, r[31], r[19:12], r[20], r[30:21], 1'b0};
                e.res = 1'b1;
                e.val = pcIn + 32'd4;
                e.br  = 1'b1;
                e.tgt = pcIn + imm;
            end
            5: begin
                ins   = {r[31:20], rs1, 3'd0, rd, 7'b1100111};
                e.res = 1'b1;
                e.val = pcIn + 32'd4;
                e.br  = 1'b1;
                e.tgt = (a + imm) & 32'hffff_fffe;
            end
            6: begin
                if (f3 == 3'd2 || f3 == 3'd3) begin
                    f3 = f3 + 3'd4;
                end
                ins   = {r[31], r[30:25], rs2, rs1, f3, r[11:8], r[7], 7'b1100011};
                e.tgt = pcIn + {{19{r[31]}}, r[31], r[7], r[30:25], r[11:8], 1'b0};
                case (f3)
                    3'd0: e.br = a == b;
                    3'd1: e.br = a != b;
                    3'd4: e.br = $signed(a) < $signed(b);
                    3'd5: e.br = $signed(a) >= $signed(b);
                    3'd6: e.br = a < b;
                    default: e.br = a >= b;
                endcase
            end
            7: begin
                if (f3 == 3'd3 || f3 > 3'd5) begin
                    f3 = 3'd2;
                end
                ins   = {r[31:20], rs1, f3, rd, 7'b0000011};
                e.dsp = 1'b1;
                e.fu  = FU_LSU;
                e.uop = f3 == 3'd0 ? LSU_LB : f3 == 3'd1 ? LSU_LH : f3 == 3'd2 ? LSU_LW :
                        f3 == 3'd4 ? LSU_LBU : LSU_LHU;
                e.a   = a;
                e.b   = imm;
                e.imm = imm;
                e.drd = rd;
            end
            8: begin
                f3    = f3[1:0] == 2'd3 ? 3'd2 : {1'b0, f3[1:0]};
                ins   = {r[31:25], rs2, rs1, f3, r[11:7], 7'b0100011};
                e.dsp = 1'b1;
                e.fu  = FU_LSU;
                e.uop = f3 == 3'd0 ? LSU_SB : f3 == 3'd1 ? LSU_SH : LSU_SW;
                e.a   = a;
                e.b   = b;
                e.imm = {{20{r[31]}}, r[31:25], r[11:7]};
                e.drd = 5'd0;
            end
            9: begin
                ins   = {7'h01, rs2, rs1, f3, rd, 7'b0110011};
                e.dsp = 1'b1;
                e.fu  = f3[2] ? FU_DIV : FU_MUL;
                case (f3)
                    3'd0: e.uop = MUL_MUL;
                    3'd1: e.uop = MUL_MULH;
                    3'd2: e.uop = MUL_MULSU;
                    3'd3: e.uop = MUL_MULU;
                    3'd4: e.uop = DIV_DIV;
                    3'd5: e.uop = DIV_DIVU;
                    3'd6: e.uop = DIV_REM;
                    default: e.uop = DIV_REMU;
                endcase
                e.a   = a;
                e.b   = b;
                e.imm = 32'd0;
                e.drd = rd;
            end
            default: begin
                // One of the reserved encodings, picked by fld[15:13].
                case (fld[15:13])
                    3'd0: ins = {r[31:7], 7'b1110011};
                    3'd1: ins = {r[31:15], fld[17] ? 3'd3 : (fld[16] ? 3'd6 : 3'd7),
                                 r[11:7], 7'b0000011};
                    3'd2: ins = {r[31:15], fld[17] ? 3'd3 : {1'b1, r[13:12]},
                                 r[11:7], 7'b0100011};
                    3'd3: ins = {r[31:15], 2'b01, r[12], r[11:7], 7'b1100011};
                    3'd4: ins = {1'b1, r[30:25], r[24:15], 3'd1, r[11:7], 7'b0010011};
                    3'd5: ins = {1'b1, r[30:25], r[24:15], 3'd5, r[11:7], 7'b0010011};
                    3'd6: ins = {7'h20, r[24:15], r[14], 1'b1, r[12], r[11:7], 7'b0110011};
                    default: ins = {1'b1, r[30:15], r[14:12], r[11:7], 7'b0110011};
                endcase
                e.ill = 1'b1;
                e.ipc = pcIn;
            end
        endcase
        e.rd = rd;
        if (e.res && rd != 5'd0) begin
            rf[rd] = e.val;
        end
    endtask

    task automatic checkOut(input Expect e);
        checkWord("resultValid", {31'b0, e.res}, {31'b0, resultValid});
        if (e.res) begin
            checkReg("resultRd", e.rd, resultRd);
            checkWord("result", e.val, result);
        end
        checkWord("branchTaken", {31'b0, e.br}, {31'b0, branchTaken});
        if (e.br) begin
            checkWord("branchTarget", e.tgt, branchTarget);
        end
        checkWord("dispatchValid", {31'b0, e.dsp}, {31'b0, dispatchValid});
        if (e.dsp) begin
            checkFu("dispatchFu", e.fu, dispatchFu);
            checkUop("dispatchOpcode", e.uop, dispatchOpcode);
            checkWord("dispatchSrcA", e.a, dispatchSrcA);
            checkWord("dispatchSrcB", e.b, dispatchSrcB);
            checkWord("dispatchImm", e.imm, dispatchImm);
            checkReg("dispatchRd", e.drd, dispatchRd);
        end
        checkWord("illegalInstr", {31'b0, e.ill}, {31'b0, illegalInstr});
        if (e.ill) begin
            checkWord("illegalPc", e.ipc, illegalPc);
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        logic [31:0] word;
        logic [31:0] pcReg;
        Expect       e;
        int          sent;
        int          waitCnt;
        logic        cleared;
        logic        idle;
        seed       = 32'hef43_f201;
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = 32'd0;
        pc         = 32'd0;
        for (int i = 0; i < 32; i++) begin
            rf[i] = 32'd0;
        end
        pcReg = rnd() & 32'hffff_fffc;
        repeat (10) @(negedge clk);
        rstN = 1'b1;

        // The output strobes must come out of reset low.
        cleared = 1'b0;
        waitCnt = 0;
        while (!cleared) begin
            @(negedge clk);
            cleared = {resultValid, branchTaken, dispatchValid, illegalInstr} === 4'b0;
            waitCnt++;
            if (!cleared && waitCnt > 20) begin
                failOn("output strobes did not clear after reset");
            end
        end

        // Three slots are in flight between a drive and its check.
        repeat (3) pipe.push_back(noneExp());
        sent = 0;
        while (sent < 2000) begin
            @(negedge clk);
            checkOut(pipe.pop_front());
            if (rnd() % 32'd4 != 32'd0) begin
                makeInstr(pcReg, word, e);
                instrValid = 1'b1;
                instr      = word;
                pc         = pcReg;
                pcReg      = pcReg + 32'd4;
                sent++;
            end else begin
                instrValid = 1'b0;
                instr      = rnd();
                pc         = rnd();
                e          = noneExp();
            end
            pipe.push_back(e);
        end

        // Once the last expected outputs are checked, the strobes must fall.
        idle    = 1'b0;
        waitCnt = 0;
        while (!idle) begin
            @(negedge clk);
            instrValid = 1'b0;
            if (pipe.size() > 0) begin
                checkOut(pipe.pop_front());
            end else begin
                idle = {resultValid, branchTaken, dispatchValid, illegalInstr} === 4'b0;
            end
            waitCnt++;
            if (!idle && waitCnt > 10) begin
                failOn("pipeline did not drain in time");
            end
        end

        $display("** PASS **");
        $finish;
    end

endmodule

// File: test/IntCore_sva.sv
`timescale 1ns/100ps

module IntCoreSva (
    input logic               clk,
    input logic               rstN,
    input logic               resultValid,
    input logic               dispatchValid,
    input logic               illegalInstr,
    input logic               branchTaken,
    input logic               exValid,
    input CorePkg::UopOpcode  exOpcode
);
    import CorePkg::*;

    logic quiet;
    logic exBranch;

    assign quiet    = !resultValid && !dispatchValid && !illegalInstr;
    assign exBranch = exValid && exOpcode inside {INT_BEQ, INT_BNE, INT_BLT, INT_BGE,
                                                  INT_BLTU, INT_BGEU};

    // Strobes stay low in reset and in the two cycles it takes the pipe to fill.
    resetQuiet: assert property (@(posedge clk)
        (!rstN || !$past(rstN) || !$past(rstN, 2)) |=> quiet)
        else $error("output strobe raised during or just after reset");

    oneStrobe: assert property (@(posedge clk) disable iff (!rstN)
        $onehot0({resultValid, dispatchValid, illegalInstr}))
        else $error("more than one output strobe high");

    branchSlot: assert property (@(posedge clk) disable iff (!rstN)
        branchTaken |-> resultValid || $past(exBranch))
        else $error("branchTaken without a jump result or a branch micro-op");

endmodule

bind IntCore IntCoreSva sva_inst (.*);

// File: hw/IntCore.sv
`timescale 1ns/100ps

module IntCore (
    input  logic               clk,
    input  logic               rstN,
    input  logic               instrValid,
    input  logic [31:0]        instr,
    input  logic [31:0]        pc,
    output logic               resultValid,
    output logic [4:0]         resultRd,
    output logic [31:0]        result,
    output logic               branchTaken,
    output logic [31:0]        branchTarget,
    output logic               dispatchValid,
    output CorePkg::FuncUnit   dispatchFu,
    output CorePkg::UopOpcode  dispatchOpcode,
    output logic [31:0]        dispatchSrcA,
    output logic [31:0]        dispatchSrcB,
    output logic [31:0]        dispatchImm,
    output logic [4:0]         dispatchRd,
    output logic               illegalInstr,
    output logic [31:0]        illegalPc
);
    import CorePkg::*;

    // Decoder outputs.
    FuncUnit     fu;
    UopOpcode    opcode;
    logic [4:0]  rs0;
    logic [4:0]  rs1;
    logic [4:0]  rd;
    logic [31:0] imm;
    logic        immB;
    logic        invalid;

    // Register file ports and writeback.
    logic [4:0]  raddrA;
    logic [4:0]  raddrB;
    logic [31:0] readA;
    logic [31:0] readB;
    logic        wrEn;
    logic [4:0]  wrAddr;
    logic [31:0] wrData;

    // Issue to execute.
    logic        exValid;
    FuncUnit     exFu;
    UopOpcode    exOpcode;
    logic [31:0] exSrcA;
    logic [31:0] exSrcB;
    logic [31:0] exImm;
    logic [31:0] exPc;
    logic [4:0]  exRd;
    logic        exInvalid;

    InstrDecoder decoder_inst (.*);

    RegFile regFile_inst (
        .clk    (clk),
        .rstN   (rstN),
        .raddrA (raddrA),
        .raddrB (raddrB),
        .rdataA (readA),
        .rdataB (readB),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData)
    );

    IssueStage issue_inst (.*);

    ExecuteStage execute_inst (.*);

endmodule

// File: hw/ExecuteStage.sv
`timescale 1ns/100ps

module ExecuteStage (
    input  logic               clk,
    input  logic               rstN,
    input  logic               exValid,
    input  CorePkg::FuncUnit   exFu,
    input  CorePkg::UopOpcode  exOpcode,
    input  logic [31:0]        exSrcA,
    input  logic [31:0]        exSrcB,
    input  logic [31:0]        exImm,
    input  logic [31:0]        exPc,
    input  logic [4:0]         exRd,
    input  logic               exInvalid,
    output logic               wrEn,
    output logic [4:0]         wrAddr,
    output logic [31:0]        wrData,
    output logic               resultValid,
    output logic [4:0]         resultRd,
    output logic [31:0]        result,
    output logic               branchTaken,
    output logic [31:0]        branchTarget,
    output logic               dispatchValid,
    output CorePkg::FuncUnit   dispatchFu,
    output CorePkg::UopOpcode  dispatchOpcode,
    output logic [31:0]        dispatchSrcA,
    output logic [31:0]        dispatchSrcB,
    output logic [31:0]        dispatchImm,
    output logic [4:0]         dispatchRd,
    output logic               illegalInstr,
    output logic [31:0]        illegalPc
);
    import CorePkg::*;

    logic        isInt;
    logic        isBranch;
    logic        taken;
    logic [31:0] aluOut;
    logic [31:0] target;
    logic [31:0] jalrSum;

    assign isInt   = exValid && !exInvalid && exFu == FU_INT;
    assign jalrSum = exSrcA + exImm;

    always_comb begin
        isBranch = 1'b0;
        taken    = 1'b0;
        target   = exPc + exImm;
        aluOut   = '0;
        case (exOpcode)
            INT_ADD:   aluOut = exSrcA + exSrcB;
            INT_SUB:   aluOut = exSrcA - exSrcB;
            INT_SLL:   aluOut = exSrcA << exSrcB[4:0];
            INT_SLT:   aluOut = {31'b0, $signed(exSrcA) < $signed(exSrcB)};
            INT_SLTU:  aluOut = {31'b0, exSrcA < exSrcB};
            INT_XOR:   aluOut = exSrcA ^ exSrcB;
            INT_SRL:   aluOut = exSrcA >> exSrcB[4:0];
            INT_SRA:   aluOut = $signed(exSrcA) >>> exSrcB[4:0];
            INT_OR:    aluOut = exSrcA | exSrcB;
            INT_AND:   aluOut = exSrcA & exSrcB;
            INT_LUI:   aluOut = exImm;
            INT_AUIPC: aluOut = exPc + exImm;
            INT_JAL: begin
                aluOut = exPc + 32'd4;
                taken  = 1'b1;
            end
            INT_JALR: begin
                aluOut = exPc + 32'd4;
                taken  = 1'b1;
                target = {jalrSum[31:1], 1'b0};
            end
            // Branches compare rs0 with rs1, which arrives on srcB.
            INT_BEQ:  begin isBranch = 1'b1; taken = exSrcA == exSrcB; end
            INT_BNE:  begin isBranch = 1'b1; taken = exSrcA != exSrcB; end
            INT_BLT:  begin isBranch = 1'b1; taken = $signed(exSrcA) < $signed(exSrcB); end
            INT_BGE:  begin isBranch = 1'b1; taken = $signed(exSrcA) >= $signed(exSrcB); end
            INT_BLTU: begin isBranch = 1'b1; taken = exSrcA < exSrcB; end
            INT_BGEU: begin isBranch = 1'b1; taken = exSrcA >= exSrcB; end
            default:  aluOut = '0;
        endcase
    end

    // ------------------------------
    // Writeback
    // ------------------------------
    assign wrEn   = isInt && !isBranch && exRd != 5'd0;
    assign wrAddr = exRd;
    assign wrData = aluOut;

    // ------------------------------
    // Output registers
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rstN) begin
            resultValid   <= 1'b0;
            branchTaken   <= 1'b0;
            dispatchValid <= 1'b0;
            illegalInstr  <= 1'b0;
        end else begin
            resultValid   <= isInt && !isBranch;
            branchTaken   <= isInt && taken;
            dispatchValid <= exValid && !exInvalid && exFu != FU_INT;
            illegalInstr  <= exValid && exInvalid;
        end
    end

    always_ff @(posedge clk) begin
        resultRd       <= exRd;
        result         <= aluOut;
        branchTarget   <= target;
        dispatchFu     <= exFu;
        dispatchOpcode <= exOpcode;
        dispatchSrcA   <= exSrcA;
        dispatchSrcB   <= exSrcB;
        dispatchImm    <= exImm;
        dispatchRd     <= exRd;
        illegalPc      <= exPc;
    end

endmodule

// File: hw/IssueStage.sv
`timescale 1ns/100ps

module IssueStage (
    input  logic               clk,
    input  logic               rstN,
    input  logic               instrValid,
    input  logic [31:0]        pc,
    input  CorePkg::FuncUnit   fu,
    input  CorePkg::UopOpcode  opcode,
    input  logic [4:0]         rs0,
    input  logic [4:0]         rs1,
    input  logic [4:0]         rd,
    input  logic [31:0]        imm,
    input  logic               immB,
    input  logic               invalid,
    input  logic [31:0]        readA,
    input  logic [31:0]        readB,
    input  logic               wrEn,
    input  logic [4:0]         wrAddr,
    input  logic [31:0]        wrData,
    output logic [4:0]         raddrA,
    output logic [4:0]         raddrB,
    output logic               exValid,
    output CorePkg::FuncUnit   exFu,
    output CorePkg::UopOpcode  exOpcode,
    output logic [31:0]        exSrcA,
    output logic [31:0]        exSrcB,
    output logic [31:0]        exImm,
    output logic [31:0]        exPc,
    output logic [4:0]         exRd,
    output logic               exInvalid
);
    import CorePkg::*;

    logic        issValid;
    FuncUnit     issFu;
    UopOpcode    issOpcode;
    logic [4:0]  issRs0;
    logic [4:0]  issRs1;
    logic [4:0]  issRd;
    logic [31:0] issImm;
    logic [31:0] issPc;
    logic        issImmB;
    logic        issInvalid;
    logic [31:0] fwdA;
    logic [31:0] fwdB;

    // ------------------------------
    // Issue register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rstN) begin
            issValid <= 1'b0;
        end else begin
            issValid <= instrValid;
        end
    end

    always_ff @(posedge clk) begin
        issFu      <= fu;
        issOpcode  <= opcode;
        issRs0     <= rs0;
        issRs1     <= rs1;
        issRd      <= rd;
        issImm     <= imm;
        issImmB    <= immB;
        issPc      <= pc;
        issInvalid <= invalid;
    end

    // ------------------------------
    // Operand read and forwarding
    // ------------------------------
    assign raddrA = issRs0;
    assign raddrB = issRs1;

    // wrEn stays low for rd 0, so x0 is never forwarded.
    assign fwdA = (wrEn && wrAddr == issRs0) ? wrData : readA;
    assign fwdB = (wrEn && wrAddr == issRs1) ? wrData : readB;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            exValid <= 1'b0;
        end else begin
            exValid <= issValid;
        end
    end

    always_ff @(posedge clk) begin
        exFu      <= issFu;
        exOpcode  <= issOpcode;
        exSrcA    <= fwdA;
        exSrcB    <= issImmB ? issImm : fwdB;
        exImm     <= issImm;
        exPc      <= issPc;
        exRd      <= issRd;
        exInvalid <= issInvalid;
    end

endmodule

// File: hw/RegFile.sv
`timescale 1ns/100ps

module RegFile (
    input  logic        clk,
    input  logic        rstN,
    input  logic [4:0]  raddrA,
    input  logic [4:0]  raddrB,
    output logic [31:0] rdataA,
    output logic [31:0] rdataB,
    input  logic        wrEn,
    input  logic [4:0]  wrAddr,
    input  logic [31:0] wrData
);

    logic [31:0] regs [32];

    // x0 is cleared by reset and never written.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            regs <= '{default: '0};
        end else if (wrEn && wrAddr != 5'd0) begin
            regs[wrAddr] <= wrData;
        end
    end

    assign rdataA = regs[raddrA];
    assign rdataB = regs[raddrB];

endmodule

// File: hw/decode/InstrDecoder.sv
`timescale 1ns/100ps

module InstrDecoder (
    input  logic [31:0]        instr,
    output logic [31:0]        imm,
    output logic [4:0]         rs0,
    output logic [4:0]         rs1,
    output logic [4:0]         rd,
    output logic               immB,
    output CorePkg::FuncUnit   fu,
    output CorePkg::UopOpcode  opcode,
    output logic               invalid
);
    import CorePkg::*;

    RvOpcode     major;
    logic [6:0]  funct7;
    logic [2:0]  funct3;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immBranch;
    logic [31:0] immJ;
    logic [31:0] immU;

    assign major  = RvOpcode'(instr[6:0]);
    assign funct7 = instr[31:25];
    assign funct3 = instr[14:12];

    assign immI      = {{20{instr[31]}}, instr[31:20]};
    assign immS      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immBranch = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immJ      = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign immU      = {instr[31:12], 12'b0};

    // Shared by OP and OP-IMM. alt selects SUB or SRA.
    function automatic UopOpcode aluOp(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0: aluOp = alt ? INT_SUB : INT_ADD;
            3'd1: aluOp = INT_SLL;
            3'd2: aluOp = INT_SLT;
            3'd3: aluOp = INT_SLTU;
            3'd4: aluOp = INT_XOR;
            3'd5: aluOp = alt ? INT_SRA : INT_SRL;
            3'd6: aluOp = INT_OR;
            default: aluOp = INT_AND;
        endcase
    endfunction

    always_comb begin
        fu      = FU_INT;
        opcode  = INT_ADD;
        rs0     = '0;
        rs1     = '0;
        rd      = '0;
        imm     = '0;
        immB    = 1'b0;
        invalid = 1'b0;

        case (major)
            OPC_LUI, OPC_AUIPC: begin
                rd     = instr[11:7];
                imm    = immU;
                immB   = 1'b1;
                opcode = (major == OPC_LUI) ? INT_LUI : INT_AUIPC;
            end
            OPC_JAL: begin
                rd     = instr[11:7];
                imm    = immJ;
                immB   = 1'b1;
                opcode = INT_JAL;
            end
            OPC_JALR: begin
                rs0    = instr[19:15];
                rd     = instr[11:7];
                imm    = immI;
                immB   = 1'b1;
                opcode = INT_JALR;
            end
            OPC_LOAD: begin
                fu   = FU_LSU;
                rs0  = instr[19:15];
                rd   = instr[11:7];
                imm  = immI;
                immB = 1'b1;
                case (funct3)
                    3'd0: opcode = LSU_LB;
                    3'd1: opcode = LSU_LH;
                    3'd2: opcode = LSU_LW;
                    3'd4: opcode = LSU_LBU;
                    3'd5: opcode = LSU_LHU;
                    default: invalid = 1'b1;
                endcase
            end
            OPC_STORE: begin
                fu  = FU_LSU;
                rs0 = instr[19:15];
                rs1 = instr[24:20];
                imm = immS;
                case (funct3)
                    3'd0: opcode = LSU_SB;
                    3'd1: opcode = LSU_SH;
                    3'd2: opcode = LSU_SW;
                    default: invalid = 1'b1;
                endcase
            end
            OPC_BRANCH: begin
                rs0 = instr[19:15];
                rs1 = instr[24:20];
                imm = immBranch;
                case (funct3)
                    3'd0: opcode = INT_BEQ;
                    3'd1: opcode = INT_BNE;
                    3'd4: opcode = INT_BLT;
                    3'd5: opcode = INT_BGE;
                    3'd6: opcode = INT_BLTU;
                    3'd7: opcode = INT_BGEU;
                    default: invalid = 1'b1;
                endcase
            end
            OPC_REG_IMM: begin
                rs0     = instr[19:15];
                rd      = instr[11:7];
                imm     = immI;
                immB    = 1'b1;
                opcode  = aluOp(funct3, funct3 == 3'd5 && funct7 == 7'h20);
                invalid = (funct3 == 3'd1 && funct7 != 7'h00) ||
                          (funct3 == 3'd5 && funct7 != 7'h00 && funct7 != 7'h20);
            end
            OPC_REG_REG: begin
                rs0 = instr[19:15];
                rs1 = instr[24:20];
                rd  = instr[11:7];
                if (funct7 == 7'h00) begin
                    opcode = aluOp(funct3, 1'b0);
                end else if (funct7 == 7'h01) begin
                    fu = funct3[2] ? FU_DIV : FU_MUL;
                    case (funct3)
                        3'd0: opcode = MUL_MUL;
                        3'd1: opcode = MUL_MULH;
                        3'd2: opcode = MUL_MULSU;
                        3'd3: opcode = MUL_MULU;
                        3'd4: opcode = DIV_DIV;
                        3'd5: opcode = DIV_DIVU;
                        3'd6: opcode = DIV_REM;
                        default: opcode = DIV_REMU;
                    endcase
                end else if (funct7 == 7'h20) begin
                    opcode  = aluOp(funct3, 1'b1);
                    invalid = funct3 != 3'd0 && funct3 != 3'd5;
                end else begin
                    invalid = 1'b1;
                end
            end
            default: invalid = 1'b1;
        endcase
    end

endmodule

// File: common/CorePkg.sv
package CorePkg;

    // ------------------------------
    // RV32 major opcodes
    // ------------------------------
    typedef enum logic [6:0] {
        OPC_LUI     = 7'b0110111,
        OPC_AUIPC   = 7'b0010111,
        OPC_JAL     = 7'b1101111,
        OPC_JALR    = 7'b1100111,
        OPC_LOAD    = 7'b0000011,
        OPC_STORE   = 7'b0100011,
        OPC_BRANCH  = 7'b1100011,
        OPC_REG_IMM = 7'b0010011,
        OPC_REG_REG = 7'b0110011
    } RvOpcode;

    // Unit that owns a micro-op. Only FU_INT executes in this core.
    typedef enum logic [1:0] {
        FU_INT,
        FU_LSU,
        FU_MUL,
        FU_DIV
    } FuncUnit;

    // ------------------------------
    // Micro-op codes
    // ------------------------------
    typedef enum logic [5:0] {
        INT_ADD, INT_SUB, INT_SLL, INT_SLT, INT_SLTU,
        INT_XOR, INT_SRL, INT_SRA, INT_OR, INT_AND,
        INT_LUI, INT_AUIPC, INT_JAL, INT_JALR,
        INT_BEQ, INT_BNE, INT_BLT, INT_BGE, INT_BLTU, INT_BGEU,
        LSU_LB, LSU_LH, LSU_LW, LSU_LBU, LSU_LHU,
        LSU_SB, LSU_SH, LSU_SW,
        MUL_MUL, MUL_MULH, MUL_MULSU, MUL_MULU,
        DIV_DIV, DIV_DIVU, DIV_REM, DIV_REMU
    } UopOpcode;

endpackage
